//--- Makefile
TOP = riscv_pipeline_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+source
+incdir+verif
source/riscv_pipe_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/writeback_unit.sv
source/riscv_pipeline.sv
verif/riscv_pipeline_checker.sv
verif/riscv_pipeline_tb.sv

//--- source/decode_unit.sv
`timescale 1ns/1ps
`include "riscv_pipe_config.svh"

module decode_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  riscv_pipe_pkg::word_t     instruction,
    input  riscv_pipe_pkg::word_t     id_pc,
    input  logic                      mem_branch_taken,
    input  logic                      wb_branch_taken,
    output logic                      stall,
    output riscv_pipe_pkg::word_t     ex_instr,
    output riscv_pipe_pkg::word_t     ex_pc,
    output riscv_pipe_pkg::word_t     ex_imm,
    output riscv_pipe_pkg::ctrl_t     ex_ctrl,
    output riscv_pipe_pkg::reg_addr_t rs1,
    output riscv_pipe_pkg::reg_addr_t rs2
);
    import riscv_pipe_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    funct3_t    funct3;
    ctrl_t      id_ctrl;
    word_t      id_imm;
    logic       id_valid;
    logic       bubble;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // lui adds its immediate to x0
    assign rs1 = (opcode == `OPC_LUI) ? reg_addr_t'(0) : instruction[19:15];
    assign rs2 = instruction[24:20];

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        id_ctrl = '0;
        case (opcode)
            `OPC_OP, `OPC_IMM: begin
                id_ctrl.reg_write   = 1'b1;
                id_ctrl.alu_src_imm = (opcode == `OPC_IMM);
                case (funct3)
                    `F3_ADD: id_ctrl.alu_op = (opcode == `OPC_OP && funct7 == `F7_ALT) ?
                                              ALU_SUB : ALU_ADD;
                    `F3_SLL:  id_ctrl.alu_op = ALU_SLL;
                    `F3_SLT:  id_ctrl.alu_op = ALU_SLT;
                    `F3_SLTU: id_ctrl.alu_op = ALU_SLTU;
                    `F3_XOR:  id_ctrl.alu_op = ALU_XOR;
                    `F3_SRL:  id_ctrl.alu_op = (funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL;
                    `F3_OR:   id_ctrl.alu_op = ALU_OR;
                    `F3_AND:  id_ctrl.alu_op = ALU_AND;
                endcase
            end
            // Word accesses only, address is rs1 plus offset
            `OPC_LOAD: begin
                if (funct3 == `F3_WORD) begin
                    id_ctrl.alu_src_imm = 1'b1;
                    id_ctrl.mem_read    = 1'b1;
                    id_ctrl.reg_write   = 1'b1;
                end
            end
            `OPC_STORE: begin
                if (funct3 == `F3_WORD) begin
                    id_ctrl.alu_src_imm = 1'b1;
                    id_ctrl.mem_write   = 1'b1;
                end
            end
            `OPC_LUI: begin
                id_ctrl.alu_src_imm = 1'b1;
                id_ctrl.reg_write   = 1'b1;
            end
            `OPC_BRANCH: id_ctrl.branch = 1'b1;
            default: ;
        endcase
    end

    // Immediate by instruction format
    always_comb begin
        case (opcode)
            `OPC_STORE:  id_imm = {{20{instruction[31]}}, instruction[31:25],
                                   instruction[11:7]};
            `OPC_BRANCH: id_imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                                   instruction[30:25], instruction[11:8], 1'b0};
            `OPC_LUI:    id_imm = {instruction[31:12], 12'b0};
            default:     id_imm = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hazards and the execute register
    ////////////////////////////////////////////////////////////////////////////

    // Load in execute feeding the instruction in decode
    assign stall = ex_ctrl.mem_read && ex_instr[11:7] != '0 &&
                   (ex_instr[11:7] == rs1 || ex_instr[11:7] == rs2) && !mem_branch_taken;

    // Decode holds a stale word in the first cycle after reset
    assign bubble = stall || mem_branch_taken || wb_branch_taken || !id_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            ex_instr <= `RISCV_NOP;
            ex_ctrl  <= '0;
        end else begin
            id_valid <= 1'b1;
            if (bubble) begin
                ex_instr <= `RISCV_NOP;
                ex_ctrl  <= '0;
            end else begin
                ex_instr <= instruction;
                ex_ctrl  <= id_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        ex_pc  <= id_pc;
        ex_imm <= id_imm;
    end

endmodule

//--- source/execute_unit.sv
`timescale 1ns/1ps
`include "riscv_pipe_config.svh"

module execute_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  riscv_pipe_pkg::word_t     ex_instr,
    input  riscv_pipe_pkg::word_t     ex_pc,
    input  riscv_pipe_pkg::word_t     ex_imm,
    input  riscv_pipe_pkg::ctrl_t     ex_ctrl,
    input  riscv_pipe_pkg::word_t     rs1_data,
    input  riscv_pipe_pkg::word_t     rs2_data,
    input  logic                      wb_reg_write,
    input  riscv_pipe_pkg::reg_addr_t wb_rd,
    input  riscv_pipe_pkg::word_t     wb_data,
    output riscv_pipe_pkg::word_t     data_addr,
    output riscv_pipe_pkg::word_t     write_data,
    output logic                      mem_read,
    output logic                      mem_write,
    output riscv_pipe_pkg::reg_addr_t mem_rd,
    output logic                      mem_reg_write,
    output logic                      mem_branch_taken,
    output riscv_pipe_pkg::word_t     mem_branch_target
);
    import riscv_pipe_pkg::*;

    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    funct3_t   ex_funct3;
    word_t     fwd_a;
    word_t     fwd_b;
    word_t     alu_b;
    word_t     alu_result;
    logic      br_eq;
    logic      br_lt;
    logic      br_ltu;
    logic      br_cond;

    // lui has no rs1, its upper bits must not match a forwarding source
    assign ex_rs1    = (ex_instr[6:0] == `OPC_LUI) ? reg_addr_t'(0) : ex_instr[19:15];
    assign ex_rs2    = ex_instr[24:20];
    assign ex_funct3 = ex_instr[14:12];

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding, memory stage has priority over writeback
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t forward(input reg_addr_t src, input word_t reg_value);
        if (src != '0 && mem_reg_write && mem_rd == src)
            return data_addr;
        if (src != '0 && wb_reg_write && wb_rd == src)
            return wb_data;
        return reg_value;
    endfunction

    always_comb begin
        fwd_a = forward(ex_rs1, rs1_data);
        fwd_b = forward(ex_rs2, rs2_data);
    end

    // Store data keeps the forwarded register, only the ALU sees the immediate
    assign alu_b = ex_ctrl.alu_src_imm ? ex_imm : fwd_b;

    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_ADD:  alu_result = fwd_a + alu_b;
            ALU_SUB:  alu_result = fwd_a - alu_b;
            ALU_SLT:  alu_result = {31'b0, $signed(fwd_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, fwd_a < alu_b};
            ALU_XOR:  alu_result = fwd_a ^ alu_b;
            ALU_OR:   alu_result = fwd_a | alu_b;
            ALU_AND:  alu_result = fwd_a & alu_b;
            ALU_SLL:  alu_result = fwd_a << alu_b[4:0];
            ALU_SRL:  alu_result = fwd_a >> alu_b[4:0];
            ALU_SRA:  alu_result = $signed(fwd_a) >>> alu_b[4:0];
            default:  alu_result = fwd_a + alu_b;
        endcase
    end

    // Branch compare on the forwarded operands
    assign br_eq  = (fwd_a == fwd_b);
    assign br_lt  = ($signed(fwd_a) < $signed(fwd_b));
    assign br_ltu = (fwd_a < fwd_b);

    always_comb begin
        case (ex_funct3)
            `F3_BEQ:  br_cond = br_eq;
            `F3_BNE:  br_cond = !br_eq;
            `F3_BLT:  br_cond = br_lt;
            `F3_BGE:  br_cond = !br_lt;
            `F3_BLTU: br_cond = br_ltu;
            `F3_BGEU: br_cond = !br_ltu;
            default:  br_cond = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory stage register
    ////////////////////////////////////////////////////////////////////////////

    // A taken branch leaves a bubble behind it
    always_ff @(posedge clk) begin
        if (rst || mem_branch_taken) begin
            mem_read         <= 1'b0;
            mem_write        <= 1'b0;
            mem_reg_write    <= 1'b0;
            mem_branch_taken <= 1'b0;
        end else begin
            mem_read         <= ex_ctrl.mem_read;
            mem_write        <= ex_ctrl.mem_write;
            mem_reg_write    <= ex_ctrl.reg_write;
            mem_branch_taken <= ex_ctrl.branch && br_cond;
        end
    end

    always_ff @(posedge clk) begin
        data_addr         <= alu_result;
        write_data        <= fwd_b;
        mem_rd            <= ex_instr[11:7];
        mem_branch_target <= ex_pc + ex_imm;
    end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`include "riscv_pipe_config.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  mem_branch_taken,
    input  riscv_pipe_pkg::word_t mem_branch_target,
    output riscv_pipe_pkg::word_t pc,
    output riscv_pipe_pkg::word_t id_pc,
    output logic                  imem_read
);
    import riscv_pipe_pkg::*;

    word_t next_pc;

    // Instruction memory is read on every edge unless decode is held
    assign imem_read = !stall;

    // A taken branch in the memory stage overrides sequential fetch
    always_comb begin
        if (mem_branch_taken)
            next_pc = mem_branch_target;
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= `RISCV_INITIAL_PC;
        else if (!stall)
            pc <= next_pc;
    end

    // PC of the word arriving on the instruction bus
    always_ff @(posedge clk) begin
        if (!stall)
            id_pc <= pc;
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps
`include "riscv_pipe_config.svh"

module register_file (
    input  logic                      clk,
    input  logic                      rst,
    input  riscv_pipe_pkg::reg_addr_t rs1,
    input  riscv_pipe_pkg::reg_addr_t rs2,
    input  logic                      wr_en,
    input  riscv_pipe_pkg::reg_addr_t wr_addr,
    input  riscv_pipe_pkg::word_t     wr_data,
    output riscv_pipe_pkg::word_t     rs1_data,
    output riscv_pipe_pkg::word_t     rs2_data
);
    import riscv_pipe_pkg::*;

    word_t regs [`RISCV_REG_NUM];

    // One read port; a write on the same edge is passed straight through
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wr_en && wr_addr == addr)
            return wr_data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RISCV_REG_NUM; i++)
                regs[i] <= '0;
            rs1_data <= '0;
            rs2_data <= '0;
        end else begin
            if (wr_en && wr_addr != '0)
                regs[wr_addr] <= wr_data;
            rs1_data <= read_port(rs1);
            rs2_data <= read_port(rs2);
        end
    end

endmodule

//--- source/riscv_pipe_config.svh
`ifndef RISCV_PIPE_CONFIG_SVH
`define RISCV_PIPE_CONFIG_SVH

// Core constants
`define RISCV_INITIAL_PC 32'h0000_0000
`define RISCV_REG_NUM    32
`define RISCV_NOP        32'h0000_0013

// Major opcodes
`define OPC_OP     7'b0110011
`define OPC_IMM    7'b0010011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011

// Branch conditions
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// ALU functions
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// Word access width for loads and stores
`define F3_WORD 3'b010

// Selects sub and sra
`define F7_ALT 7'b0100000

`endif

//--- source/riscv_pipe_pkg.sv
package riscv_pipe_pkg;

    // Datapath widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    // ALU operations, ADD first so an all-zero control word is a plain add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Control word carried from decode into execute
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_t alu_op;
        // Operand B comes from the immediate
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        // Conditional branch, resolved at the end of execute
        logic    branch;
    } ctrl_t;

endpackage

//--- source/riscv_pipeline.sv
`timescale 1ns/1ps

module riscv_pipeline (
    input  logic                  clk,
    input  logic                  rst,
    input  riscv_pipe_pkg::word_t instruction,
    input  riscv_pipe_pkg::word_t read_data,
    output riscv_pipe_pkg::word_t pc,
    output logic                  imem_read,
    output riscv_pipe_pkg::word_t data_addr,
    output riscv_pipe_pkg::word_t write_data,
    output logic                  mem_read,
    output logic                  mem_write,
    output riscv_pipe_pkg::word_t wb_data
);
    import riscv_pipe_pkg::*;

    // Fetch and decode
    word_t     id_pc;
    logic      stall;
    reg_addr_t rs1;
    reg_addr_t rs2;

    // Execute
    word_t     ex_instr;
    word_t     ex_pc;
    word_t     ex_imm;
    ctrl_t     ex_ctrl;
    word_t     rs1_data;
    word_t     rs2_data;

    // Memory and writeback
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    logic      mem_branch_taken;
    word_t     mem_branch_target;
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    logic      wb_branch_taken;

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////

    fetch_unit fetch0 (
        .clk(clk), .rst(rst), .stall(stall),
        .mem_branch_taken(mem_branch_taken), .mem_branch_target(mem_branch_target),
        .pc(pc), .id_pc(id_pc), .imem_read(imem_read)
    );

    register_file regs0 (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .wr_en(wb_reg_write), .wr_addr(wb_rd), .wr_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    decode_unit decode0 (
        .clk(clk), .rst(rst), .instruction(instruction), .id_pc(id_pc),
        .mem_branch_taken(mem_branch_taken), .wb_branch_taken(wb_branch_taken),
        .stall(stall), .ex_instr(ex_instr), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_ctrl(ex_ctrl), .rs1(rs1), .rs2(rs2)
    );

    execute_unit execute0 (
        .clk(clk), .rst(rst), .ex_instr(ex_instr), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_ctrl(ex_ctrl), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_data(wb_data),
        .data_addr(data_addr), .write_data(write_data),
        .mem_read(mem_read), .mem_write(mem_write),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
        .mem_branch_taken(mem_branch_taken), .mem_branch_target(mem_branch_target)
    );

    writeback_unit writeback0 (
        .clk(clk), .rst(rst), .data_addr(data_addr), .mem_read(mem_read),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
        .mem_branch_taken(mem_branch_taken), .read_data(read_data),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_data(wb_data),
        .wb_branch_taken(wb_branch_taken)
    );

endmodule

//--- source/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  riscv_pipe_pkg::word_t     data_addr,
    input  logic                      mem_read,
    input  riscv_pipe_pkg::reg_addr_t mem_rd,
    input  logic                      mem_reg_write,
    input  logic                      mem_branch_taken,
    input  riscv_pipe_pkg::word_t     read_data,
    output riscv_pipe_pkg::reg_addr_t wb_rd,
    output logic                      wb_reg_write,
    output riscv_pipe_pkg::word_t     wb_data,
    output logic                      wb_branch_taken
);
    import riscv_pipe_pkg::*;

    word_t wb_result;
    logic  wb_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_reg_write    <= 1'b0;
            wb_load         <= 1'b0;
            wb_branch_taken <= 1'b0;
        end else begin
            wb_reg_write    <= mem_reg_write;
            wb_load         <= mem_read;
            // Squashes the word still sitting in decode
            wb_branch_taken <= mem_branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        wb_result <= data_addr;
        wb_rd     <= mem_rd;
    end

    // Load data arrives one cycle after the read strobe
    assign wb_data = wb_load ? read_data : wb_result;

endmodule

//--- verif/riscv_pipeline_checker.sv
`timescale 1ns/1ps

module riscv_pipeline_checker (
    input logic                  clk,
    input logic                  rst,
    input riscv_pipe_pkg::word_t pc,
    input logic                  imem_read,
    input logic                  mem_read,
    input logic                  mem_write
);

    a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write)) else $error("mem_read and mem_write both high");

    // No write in reset or in the first cycle after it
    a_reset_write: assert property (@(posedge clk) rst |=> !mem_write)
        else $error("mem_write high during reset");
    a_after_reset: assert property (@(posedge clk) rst ##1 !rst |=> !mem_write)
        else $error("mem_write high right after reset");

    a_pc_hold: assert property (@(posedge clk) disable iff (rst)
        !imem_read |=> $stable(pc)) else $error("pc moved while fetch was held");

    a_pc_align: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

bind riscv_pipeline riscv_pipeline_checker check0 (
    .clk(clk), .rst(rst), .pc(pc), .imem_read(imem_read),
    .mem_read(mem_read), .mem_write(mem_write)
);

//--- verif/riscv_iss_model.svh
`ifndef RISCV_ISS_MODEL_SVH
`define RISCV_ISS_MODEL_SVH

// Reference ALU where alt selects sub and sra
function automatic word_t model_alu(input funct3_t f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
        `F3_ADD:  return alt ? a - b : a + b;
        `F3_SLL:  return a << b[4:0];
        `F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
        `F3_XOR:  return a ^ b;
        `F3_SRL:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        `F3_OR:   return a | b;
        default:  return a & b;
    endcase
endfunction

function automatic logic model_branch(input funct3_t f3, input word_t a, input word_t b);
    case (f3)
        `F3_BEQ:  return a == b;
        `F3_BNE:  return a != b;
        `F3_BLT:  return $signed(a) < $signed(b);
        `F3_BGE:  return $signed(a) >= $signed(b);
        `F3_BLTU: return a < b;
        default:  return a >= b;
    endcase
endfunction

// Runs the program one instruction at a time and records every store and load
task automatic run_model();
    word_t      regs [32];
    word_t      mem [256];
    word_t      pc_m;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      addr;
    logic [6:0] op;
    funct3_t    f3;
    for (int i = 0; i < 32; i++)
        regs[i] = '0;
    for (int i = 0; i < 256; i++)
        mem[i] = init_word(i);
    pc_m = `RISCV_INITIAL_PC;
    for (int step = 0; step < 1000; step++) begin
        ins = imem[pc_m[8:2]];
        op  = ins[6:0];
        f3  = ins[14:12];
        a   = regs[ins[19:15]];
        b   = regs[ins[24:20]];
        case (op)
            `OPC_OP:
                regs[ins[11:7]] = model_alu(f3, ins[30] && (f3 == `F3_ADD || f3 == `F3_SRL),
                                            a, b);
            `OPC_IMM:
                regs[ins[11:7]] = model_alu(f3, ins[30] && f3 == `F3_SRL, a,
                                            {{20{ins[31]}}, ins[31:20]});
            `OPC_LUI:
                regs[ins[11:7]] = {ins[31:12], 12'b0};
            `OPC_LOAD: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                regs[ins[11:7]] = mem[addr[9:2]];
                exp_load.push_back(mem[addr[9:2]]);
            end
            `OPC_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem[addr[9:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            default: begin
                if (model_branch(f3, a, b)) begin
                    addr = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    // A branch to itself ends the program
                    if (addr == '0)
                        break;
                    pc_m = pc_m + addr - 32'd4;
                end
            end
        endcase
        regs[0] = '0;
        pc_m = pc_m + 32'd4;
    end
endtask

task automatic check_addr(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_data(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

`endif

//--- verif/riscv_pipeline_tb.sv
`timescale 1ns/1ps
`include "riscv_pipe_config.svh"

module riscv_pipeline_tb;
    import riscv_pipe_pkg::*;

    localparam int PROG_LEN  = 120;
    localparam int RAND_LEN  = 88;
    localparam int MAX_CYCLE = 4 * 160 + 50;

    logic  clk = 1'b0;
    logic  rst;
    word_t instruction;
    word_t read_data;
    word_t pc;
    logic  imem_read;
    word_t data_addr;
    word_t write_data;
    logic  mem_read;
    logic  mem_write;
    word_t wb_data;

    word_t       imem [128];
    word_t       dmem [256];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       exp_load [$];
    logic [31:0] rng = 32'd91965;
    int          errors = 0;
    int          seen = 0;
    int          loads = 0;
    int          cycles = 0;
    logic        done = 1'b0;

    // Bus values sampled mid-cycle for the next rising edge
    logic        fetch_en;
    word_t       fetch_pc;
    logic        rd_en;
    logic        wr_en;
    word_t       d_addr;
    word_t       d_wdata;

    function automatic word_t init_word(input int i);
        return (32'(i) * 32'h9e37_79b9) ^ {24'h5a3c1e, 8'(i)};
    endfunction

    `include "riscv_iss_model.svh"

    riscv_pipeline dut0 (
        .clk(clk), .rst(rst), .instruction(instruction), .read_data(read_data),
        .pc(pc), .imem_read(imem_read), .data_addr(data_addr), .write_data(write_data),
        .mem_read(mem_read), .mem_write(mem_write), .wb_data(wb_data)
    );

    always #4 clk = ~clk;

    // Upper halves of two LCG steps
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        rng = rng * 32'd1103515245 + 32'd12345;
        hi  = rng[31:16];
        rng = rng * 32'd1103515245 + 32'd12345;
        return {hi, rng[31:16]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    task automatic build_program();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        funct3_t     f3;
        logic [31:0] r;
        logic [31:0] v;
        logic [6:0]  f7;
        logic [11:0] off;
        for (int i = 0; i < 128; i++)
            imem[i] = `RISCV_NOP;
        for (int i = 0; i < RAND_LEN; i++) begin
            r   = next_rand();
            v   = next_rand();
            rd  = r[8:4];
            rs1 = r[13:9];
            rs2 = r[18:14];
            f3  = r[21:19];
            f7  = v[0] && (f3 == `F3_ADD || f3 == `F3_SRL) ? `F7_ALT : 7'b0;
            off = {2'b00, v[9:2], 2'b00};
            case (r[31:22] % 10)
                0, 1, 2: imem[i] = {f7, rs2, rs1, f3, rd, `OPC_OP};
                3, 4: begin
                    if (f3 == `F3_SLL || f3 == `F3_SRL)
                        imem[i] = {(f3 == `F3_SRL) ? f7 : 7'b0, v[24:20], rs1, f3, rd,
                                   `OPC_IMM};
                    else
                        imem[i] = {v[31:20], rs1, f3, rd, `OPC_IMM};
                end
                5: imem[i] = {v[31:12], rd, `OPC_LUI};
                6, 7: imem[i] = {off, 5'd0, `F3_WORD, rd, `OPC_LOAD};
                8: imem[i] = enc_s(off, rs2, 5'd0);
                default: begin
                    // Forward only and at most eight words ahead
                    case (v[30:20] % 6)
                        0: f3 = `F3_BEQ;
                        1: f3 = `F3_BNE;
                        2: f3 = `F3_BLT;
                        3: f3 = `F3_BGE;
                        4: f3 = `F3_BLTU;
                        default: f3 = `F3_BGEU;
                    endcase
                    imem[i] = enc_b(13'((v[14:12] + 1) * 4), rs2, rs1, f3);
                end
            endcase
        end
        // Dump of x1 to x31 and then a branch to itself
        for (int j = 1; j < 32; j++)
            imem[RAND_LEN - 1 + j] = enc_s(12'((200 + j) * 4), reg_addr_t'(j), 5'd0);
        imem[PROG_LEN - 1] = enc_b(13'd0, 5'd0, 5'd0, `F3_BEQ);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memories and store monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        // Data of the read strobe one cycle back is on wb_data now
        if (rd_en) begin
            if (loads >= exp_load.size()) begin
                errors++;
                $display("Load seen beyond the expected count at %0t", $time);
            end else begin
                check_data("wb_data", exp_load[loads], wb_data);
                loads++;
            end
        end
        fetch_en = imem_read;
        fetch_pc = pc;
        rd_en    = !rst && mem_read;
        wr_en    = !rst && mem_write;
        d_addr   = data_addr;
        d_wdata  = write_data;
        if (wr_en) begin
            if (seen >= exp_addr.size()) begin
                errors++;
                $display("Store seen beyond the expected count at %0t", $time);
            end else begin
                check_addr("data_addr", exp_addr[seen], d_addr);
                check_data("write_data", exp_data[seen], d_wdata);
                seen++;
                done = (seen == exp_addr.size());
            end
        end
    end

    always @(posedge clk) begin
        if (!rst)
            cycles++;
        #1;
        if (fetch_en)
            instruction = imem[fetch_pc[8:2]];
        if (wr_en)
            dmem[d_addr[9:2]] = d_wdata;
        if (rd_en)
            read_data = dmem[d_addr[9:2]];
    end

    initial begin
        rst         = 1'b1;
        instruction = `RISCV_NOP;
        read_data   = '0;
        fetch_en    = 1'b0;
        rd_en       = 1'b0;
        wr_en       = 1'b0;
        for (int i = 0; i < 256; i++)
            dmem[i] = init_word(i);
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        wait (done || cycles >= MAX_CYCLE);
        repeat (4) @(posedge clk);
        if (!done) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, seen, exp_addr.size());
        end
        if (loads != exp_load.size()) begin
            errors++;
            $display("Saw %0d loads where the model made %0d", loads, exp_load.size());
        end
        $display("Stores checked: %0d, loads checked: %0d, errors: %0d",
                 seen, loads, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
